/* verilog/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ----------------------------------------------------------------------
// RV32I base widths
// ----------------------------------------------------------------------

`define XLEN      32      // data and address width
`define REG_AW    5       // register index width

// ----------------------------------------------------------------------
// sequential fetch
// ----------------------------------------------------------------------

`define INST_STEP 4       // bytes per instruction

`endif

/* verilog/rv_isa_pkg.sv */
`include "rv_macros.svh"

package rv_isa_pkg;

   typedef logic [`XLEN-1:0]   word_t;
   typedef logic [`REG_AW-1:0] reg_idx_t;
   typedef logic [31:0]        inst_t;
   typedef logic [2:0]         funct3_t;
   typedef logic [6:0]         funct7_t;

   // ----------------------------------------------------------------------
   // major opcodes handled by decode
   // ----------------------------------------------------------------------
   typedef enum logic [6:0] {
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011
   } opcode_e;

   typedef enum logic [4:0] {
      ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
      ALU_SB, ALU_SH, ALU_SW
   } alu_op_e;

   typedef enum logic [2:0] {
      SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LOAD_STORE, SEL_JUMP_BRANCH
   } alu_sel_e;

   typedef enum logic [3:0] {
      BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
   } br_cond_e;

endpackage

/* verilog/decode_pkg.sv */
package decode_pkg;

   import rv_isa_pkg::*;

   // decoder output, shared by bypass, branch and pipe register
   typedef struct packed {
      alu_op_e  alu_op;
      alu_sel_e alu_sel;
      logic     rs1_used;
      logic     rs2_used;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      logic     we;
      br_cond_e br_cond;
      word_t    imm;
      logic     imm_pc_rel;     // offset is taken from pc
   } dec_ctrl_t;

   // result of a later stage, one per stage
   typedef struct packed {
      logic     we;
      reg_idx_t rd;
      word_t    data;
      logic     is_load;
   } fwd_src_t;

   typedef struct packed {
      logic is_branch;
      logic taken;
      logic correct;
   } bp_update_t;

   typedef struct packed {
      logic     valid;
      alu_op_e  alu_op;
      alu_sel_e alu_sel;
      word_t    op1;
      word_t    op2;
      word_t    mem_off;
      reg_idx_t rd;
      logic     we;
      word_t    link_addr;
   } ex_bundle_t;

endpackage

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
   import rv_isa_pkg::*;
   import decode_pkg::*;
(
   input  word_t     pc_i,
   input  inst_t     inst_i,
   output dec_ctrl_t ctrl_o
);

   opcode_e opcode;
   funct3_t funct3;
   funct7_t funct7;
   word_t   imm_i, imm_s, imm_b, imm_u, imm_j, shamt;

   assign opcode = opcode_e'(inst_i[6:0]);
   assign funct3 = inst_i[14:12];
   assign funct7 = inst_i[31:25];

   assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
   assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
   assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
   assign imm_u = {inst_i[31:12], 12'h000};
   assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
   assign shamt = {27'd0, inst_i[24:20]};

   // ----------------------------------------------------------------------
   // OP and OP-IMM share one funct3/funct7 table
   // ----------------------------------------------------------------------
   function automatic alu_op_e arith_op(input funct3_t f3, input funct7_t f7, input logic is_imm);
      logic std;
      logic alt;
      std = (f7 == 7'b0000000);
      alt = (f7 == 7'b0100000);
      arith_op = ALU_NOP;
      case (f3)
         3'b000: arith_op = (is_imm || std) ? ALU_ADD : (alt ? ALU_SUB : ALU_NOP);
         3'b001: arith_op = std ? ALU_SLL : ALU_NOP;
         3'b010: arith_op = (is_imm || std) ? ALU_SLT : ALU_NOP;
         3'b011: arith_op = (is_imm || std) ? ALU_SLTU : ALU_NOP;
         3'b100: arith_op = (is_imm || std) ? ALU_XOR : ALU_NOP;
         3'b101: arith_op = std ? ALU_SRL : (alt ? ALU_SRA : ALU_NOP);
         3'b110: arith_op = (is_imm || std) ? ALU_OR : ALU_NOP;
         default: arith_op = (is_imm || std) ? ALU_AND : ALU_NOP;
      endcase
   endfunction

   function automatic alu_sel_e sel_of(input alu_op_e op);
      case (op)
         ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: sel_of = SEL_ARITH;
         ALU_AND, ALU_OR, ALU_XOR:            sel_of = SEL_LOGIC;
         ALU_SLL, ALU_SRL, ALU_SRA:           sel_of = SEL_SHIFT;
         default:                             sel_of = SEL_NOP;
      endcase
   endfunction

   always_comb
   begin
      ctrl_o     = '0;
      ctrl_o.rs1 = inst_i[19:15];
      ctrl_o.rs2 = inst_i[24:20];
      ctrl_o.rd  = inst_i[11:7];
      case (opcode)
         OPC_OP_IMM, OPC_OP:
         begin
            ctrl_o.alu_op   = arith_op(funct3, funct7, opcode == OPC_OP_IMM);
            ctrl_o.alu_sel  = sel_of(ctrl_o.alu_op);
            ctrl_o.rs1_used = 1'b1;
            ctrl_o.rs2_used = (opcode == OPC_OP);
            ctrl_o.we       = 1'b1;
            ctrl_o.imm      = (funct3 ==? 3'b?01) ? shamt : imm_i;  // slli/srli/srai
         end
         OPC_LOAD:
         begin
            case (funct3)
               3'b000:  ctrl_o.alu_op = ALU_LB;
               3'b001:  ctrl_o.alu_op = ALU_LH;
               3'b010:  ctrl_o.alu_op = ALU_LW;
               3'b100:  ctrl_o.alu_op = ALU_LBU;
               3'b101:  ctrl_o.alu_op = ALU_LHU;
               default: ctrl_o.alu_op = ALU_NOP;
            endcase
            ctrl_o.alu_sel  = SEL_LOAD_STORE;
            ctrl_o.rs1_used = 1'b1;
            ctrl_o.we       = 1'b1;
            ctrl_o.imm      = imm_i;
         end
         OPC_STORE:
         begin
            case (funct3)
               3'b000:  ctrl_o.alu_op = ALU_SB;
               3'b001:  ctrl_o.alu_op = ALU_SH;
               3'b010:  ctrl_o.alu_op = ALU_SW;
               default: ctrl_o.alu_op = ALU_NOP;
            endcase
            ctrl_o.alu_sel  = SEL_LOAD_STORE;
            ctrl_o.rs1_used = 1'b1;
            ctrl_o.rs2_used = 1'b1;
            ctrl_o.imm      = imm_s;                                 // offset rides along
         end
         OPC_LUI, OPC_AUIPC:
         begin
            ctrl_o.alu_op     = ALU_OR;                              // 0 | imm
            ctrl_o.alu_sel    = SEL_LOGIC;
            ctrl_o.we         = 1'b1;
            ctrl_o.imm_pc_rel = (opcode == OPC_AUIPC);
            ctrl_o.imm        = (opcode == OPC_AUIPC) ? pc_i + imm_u : imm_u;
         end
         OPC_JAL, OPC_JALR:
         begin
            ctrl_o.alu_op     = ALU_ADD;
            ctrl_o.alu_sel    = SEL_JUMP_BRANCH;
            ctrl_o.we         = 1'b1;
            ctrl_o.rs1_used   = (opcode == OPC_JALR);
            ctrl_o.br_cond    = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
            ctrl_o.imm_pc_rel = (opcode == OPC_JAL);
            ctrl_o.imm        = (opcode == OPC_JAL) ? imm_j : imm_i;
         end
         OPC_BRANCH:
         begin
            case (funct3)
               3'b000:  ctrl_o.br_cond = BR_EQ;
               3'b001:  ctrl_o.br_cond = BR_NE;
               3'b100:  ctrl_o.br_cond = BR_LT;
               3'b101:  ctrl_o.br_cond = BR_GE;
               3'b110:  ctrl_o.br_cond = BR_LTU;
               3'b111:  ctrl_o.br_cond = BR_GEU;
               default: ctrl_o.br_cond = BR_NONE;
            endcase
            ctrl_o.alu_op     = (ctrl_o.br_cond == BR_NONE) ? ALU_NOP : ALU_SUB;
            ctrl_o.alu_sel    = SEL_JUMP_BRANCH;
            ctrl_o.rs1_used   = 1'b1;
            ctrl_o.rs2_used   = 1'b1;
            ctrl_o.imm_pc_rel = 1'b1;
            ctrl_o.imm        = imm_b;
         end
         default: ctrl_o.alu_op = ALU_NOP;
      endcase
      if (ctrl_o.alu_op == ALU_NOP)                                  // unknown encoding
      begin
         ctrl_o.alu_sel    = SEL_NOP;
         ctrl_o.we         = 1'b0;
         ctrl_o.rs1_used   = 1'b0;
         ctrl_o.rs2_used   = 1'b0;
         ctrl_o.br_cond    = BR_NONE;
         ctrl_o.imm_pc_rel = 1'b0;
      end
   end

   always_comb
   begin
      a_we_has_op: assert (!(ctrl_o.we && ctrl_o.alu_op == ALU_NOP));
   end

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
   import rv_isa_pkg::*;
   import decode_pkg::*;
(
   input  dec_ctrl_t ctrl_i,
   input  fwd_src_t  ex_fwd_i,
   input  fwd_src_t  mem_fwd_i,
   input  word_t     rs1_data_i,
   input  word_t     rs2_data_i,
   output word_t     op1_o,
   output word_t     op2_o,
   output logic      load_use_o
);

   // ----------------------------------------------------------------------
   // forwarding priority: x0, execute, memory, register file
   // ----------------------------------------------------------------------
   function automatic word_t pick_src(input logic used, input reg_idx_t idx, input word_t rf,
                                      input fwd_src_t ex, input fwd_src_t mem);
      if (!used || idx == reg_idx_t'(0))
         pick_src = '0;
      else if (ex.we && ex.rd == idx)
         pick_src = ex.data;
      else if (mem.we && mem.rd == idx)
         pick_src = mem.data;
      else
         pick_src = rf;
   endfunction

   function automatic logic load_hit(input logic used, input reg_idx_t idx, input fwd_src_t ex);
      load_hit = used && idx != reg_idx_t'(0) && ex.we && ex.is_load && ex.rd == idx;
   endfunction

   assign op1_o = pick_src(ctrl_i.rs1_used, ctrl_i.rs1, rs1_data_i, ex_fwd_i, mem_fwd_i);

   assign op2_o = ctrl_i.rs2_used
                ? pick_src(1'b1, ctrl_i.rs2, rs2_data_i, ex_fwd_i, mem_fwd_i)
                : ctrl_i.imm;                                        // immediate forms

   // load data not back until after execute
   assign load_use_o = load_hit(ctrl_i.rs1_used, ctrl_i.rs1, ex_fwd_i)
                     | load_hit(ctrl_i.rs2_used, ctrl_i.rs2, ex_fwd_i);

endmodule

/* verilog/branch_resolve.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module branch_resolve
   import rv_isa_pkg::*;
   import decode_pkg::*;
(
   input  logic       inst_valid_i,
   input  word_t      pc_i,
   input  dec_ctrl_t  ctrl_i,
   input  word_t      op1_i,
   input  word_t      op2_i,
   input  logic       pred_taken_i,
   input  logic       load_use_i,
   output logic       redirect_o,
   output word_t      redirect_pc_o,
   output bp_update_t bp_update_o,
   output word_t      link_addr_o
);

   logic  active, is_branch, is_jump, taken;
   word_t seq_pc, tgt_sum, tgt_pc;

   assign active    = inst_valid_i & ~load_use_i;                    // operands stale on load-use
   assign is_jump   = (ctrl_i.br_cond == BR_JAL) || (ctrl_i.br_cond == BR_JALR);
   assign is_branch = (ctrl_i.br_cond != BR_NONE) && !is_jump;

   always_comb
   begin
      case (ctrl_i.br_cond)
         BR_EQ:   taken = (op1_i == op2_i);
         BR_NE:   taken = (op1_i != op2_i);
         BR_LT:   taken = ($signed(op1_i) < $signed(op2_i));
         BR_GE:   taken = ($signed(op1_i) >= $signed(op2_i));
         BR_LTU:  taken = (op1_i < op2_i);
         BR_GEU:  taken = (op1_i >= op2_i);
         default: taken = 1'b0;
      endcase
   end

   assign seq_pc      = pc_i + word_t'(`INST_STEP);
   assign tgt_sum     = (ctrl_i.imm_pc_rel ? pc_i : op1_i) + ctrl_i.imm;
   assign tgt_pc      = {tgt_sum[`XLEN-1:1], 1'b0};                  // jalr clears bit 0
   assign link_addr_o = seq_pc;

   assign redirect_o    = active & (is_jump | (is_branch & (taken != pred_taken_i)));
   assign redirect_pc_o = !redirect_o ? '0 : ((is_jump || taken) ? tgt_pc : seq_pc);

   assign bp_update_o.is_branch = active & is_branch;
   assign bp_update_o.taken     = active & is_branch & taken;
   assign bp_update_o.correct   = active & is_branch & (taken == pred_taken_i);

   always_comb
   begin
      a_no_redirect_on_stall: assert (!(redirect_o && load_use_i));
   end

endmodule

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg
   import rv_isa_pkg::*;
   import decode_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       stall_i,
   input  logic       bubble_i,
   input  ex_bundle_t bundle_i,
   output ex_bundle_t bundle_o
);

   ex_bundle_t bundle_q;

   // ----------------------------------------------------------------------
   // decode to execute boundary
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         bundle_q <= '0;                                             // bubble, op NOP
      end
      else if (!stall_i)
      begin
         bundle_q <= bundle_i;
         if (bubble_i)
         begin
            bundle_q.valid   <= 1'b0;
            bundle_q.we      <= 1'b0;
            bundle_q.alu_op  <= ALU_NOP;
            bundle_q.alu_sel <= SEL_NOP;
         end
      end
   end

   assign bundle_o = bundle_q;

   // bubble clearing and decoder NOP filtering must agree
   a_valid_has_op: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      bundle_o.valid |-> bundle_o.alu_op != ALU_NOP
   );

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
   import rv_isa_pkg::*;
   import decode_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       inst_valid_i,
   input  word_t      pc_i,
   input  inst_t      inst_i,
   input  logic       pred_taken_i,
   input  fwd_src_t   ex_fwd_i,
   input  fwd_src_t   mem_fwd_i,
   input  word_t      rs1_data_i,
   input  word_t      rs2_data_i,
   input  logic       stall_i,
   output reg_idx_t   rs1_addr_o,
   output reg_idx_t   rs2_addr_o,
   output logic       redirect_o,
   output word_t      redirect_pc_o,
   output bp_update_t bp_update_o,
   output logic       load_use_stall_o,
   output ex_bundle_t ex_bundle_o
);

   dec_ctrl_t  ctrl;
   word_t      op1, op2, link_addr;
   logic       load_use, bubble;
   ex_bundle_t ex_bundle;

   instr_decoder u_dec (.pc_i(pc_i), .inst_i(inst_i), .ctrl_o(ctrl));

   operand_bypass u_byp (
      .ctrl_i(ctrl), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i),
      .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
      .op1_o(op1), .op2_o(op2), .load_use_o(load_use)
   );

   branch_resolve u_br (
      .inst_valid_i(inst_valid_i), .pc_i(pc_i), .ctrl_i(ctrl), .op1_i(op1), .op2_i(op2),
      .pred_taken_i(pred_taken_i), .load_use_i(load_use), .redirect_o(redirect_o),
      .redirect_pc_o(redirect_pc_o), .bp_update_o(bp_update_o), .link_addr_o(link_addr)
   );

   assign rs1_addr_o       = inst_valid_i ? ctrl.rs1 : '0;
   assign rs2_addr_o       = inst_valid_i ? ctrl.rs2 : '0;
   assign load_use_stall_o = inst_valid_i & load_use;
   assign bubble           = ~inst_valid_i | load_use | (ctrl.alu_op == ALU_NOP);  // illegal too

   assign ex_bundle = '{valid: inst_valid_i, alu_op: ctrl.alu_op, alu_sel: ctrl.alu_sel,
                        op1: op1, op2: op2, mem_off: ctrl.imm, rd: ctrl.rd, we: ctrl.we,
                        link_addr: link_addr};

   id_ex_reg u_idex (
      .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_i), .bubble_i(bubble),
      .bundle_i(ex_bundle), .bundle_o(ex_bundle_o)
   );

endmodule

/* bench/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

localparam int NUM_ROWS = 25;

// ----------------------------------------------------------------------
// stimulus:  valid, pc, inst, pred_taken, stall, random rf, rs1, rs2, ex fwd, mem fwd
// expected:  load-use, redirect, redirect pc, bp {branch,taken,correct},
//            op, sel, rd, we, op1 source, op2 source, literal
// ----------------------------------------------------------------------
vec_row_t vectors [0:NUM_ROWS-1] = '{
   // immediate forms
   '{1'b1, 32'h1000, 32'h0640_8293, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_ARITH, 5'd5, 1'b1, S_RS1, S_LIT, 32'h64},
   '{1'b1, 32'h1004, 32'hFFB1_2313, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SLT, SEL_ARITH, 5'd6, 1'b1, S_RS1, S_LIT, 32'hFFFF_FFFB},
   '{1'b1, 32'h1008, 32'h0F01_C393, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_XOR, SEL_LOGIC, 5'd7, 1'b1, S_RS1, S_LIT, 32'hF0},
   '{1'b1, 32'h100C, 32'h0032_1413, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SLL, SEL_SHIFT, 5'd8, 1'b1, S_RS1, S_LIT, 32'h3},
   '{1'b1, 32'h1010, 32'h4072_D493, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SRA, SEL_SHIFT, 5'd9, 1'b1, S_RS1, S_LIT, 32'h7},
   '{1'b1, 32'h1014, 32'h1234_5537, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_OR, SEL_LOGIC, 5'd10, 1'b1, S_ZERO, S_LIT, 32'h1234_5000},
   '{1'b1, 32'h1018, 32'h0000_1597, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_OR, SEL_LOGIC, 5'd11, 1'b1, S_ZERO, S_LIT, 32'h2018},
   // forwarding, x0 reads zero even when a stage writes x0
   '{1'b1, 32'h101C, 32'h00E6_8633, 1'b0, 1'b0, 1'b0, 32'h0BAD_0001, 32'h0BAD_0002,
     {1'b1, 5'd13, 32'hAAAA_0001, 1'b0}, {1'b1, 5'd14, 32'hBBBB_0002, 1'b0},
     1'b0, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_ARITH, 5'd12, 1'b1, S_EX, S_MEM, 32'h0},
   '{1'b1, 32'h1020, 32'h4100_07B3, 1'b0, 1'b0, 1'b0, 32'h0BAD_0001, 32'h0BAD_0002,
     {1'b1, 5'd16, 32'hCCCC_0003, 1'b0}, {1'b1, 5'd0, 32'hDDDD_0004, 1'b0},
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SUB, SEL_ARITH, 5'd15, 1'b1, S_ZERO, S_EX, 32'h0},
   // load, load-use, then the same add once the load sits in memory
   '{1'b1, 32'h1024, 32'h0089_2883, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_LW, SEL_LOAD_STORE, 5'd17, 1'b1, S_RS1, S_LIT, 32'h8},
   '{1'b1, 32'h1028, 32'h0148_89B3, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0,
     {1'b1, 5'd17, 32'h0, 1'b1}, NO_FWD,
     1'b1, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_ARITH, 5'd19, 1'b1, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h1028, 32'h0148_89B3, 1'b0, 1'b0, 1'b0, 32'h0BAD_0001, 32'h0BAD_0002,
     NO_FWD, {1'b1, 5'd17, 32'h1234_0017, 1'b0},
     1'b0, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_ARITH, 5'd19, 1'b1, S_MEM, S_RS2, 32'h0},
   '{1'b1, 32'h102C, 32'hFF5B_2A23, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SW, SEL_LOAD_STORE, 5'd20, 1'b0, S_RS1, S_RS2,
     32'hFFFF_FFF4},
   // branches, all four outcome and prediction pairs
   '{1'b1, 32'h1030, 32'h0020_8863, 1'b1, 1'b0, 1'b0, 32'h5, 32'h5, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b111, ALU_SUB, SEL_JUMP_BRANCH, 5'd16, 1'b0, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h1034, 32'h0020_8863, 1'b0, 1'b0, 1'b0, 32'h5, 32'h5, NO_FWD, NO_FWD,
     1'b0, 1'b1, 32'h1044, 3'b110, ALU_SUB, SEL_JUMP_BRANCH, 5'd16, 1'b0, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h1038, 32'hFE41_CCE3, 1'b0, 1'b0, 1'b0, 32'hFFFF_FFFF, 32'h1, NO_FWD, NO_FWD,
     1'b0, 1'b1, 32'h1030, 3'b110, ALU_SUB, SEL_JUMP_BRANCH, 5'd25, 1'b0, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h103C, 32'hFE41_CCE3, 1'b1, 1'b0, 1'b0, 32'h5, 32'hFFFF_FFFD, NO_FWD, NO_FWD,
     1'b0, 1'b1, 32'h1040, 3'b100, ALU_SUB, SEL_JUMP_BRANCH, 5'd25, 1'b0, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h1040, 32'h0073_7863, 1'b0, 1'b0, 1'b0, 32'h1, 32'hFFFF_FFFF, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b101, ALU_SUB, SEL_JUMP_BRANCH, 5'd16, 1'b0, S_RS1, S_RS2, 32'h0},
   '{1'b1, 32'h1044, 32'h0073_7863, 1'b1, 1'b0, 1'b0, 32'h8000_0000, 32'h2, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b111, ALU_SUB, SEL_JUMP_BRANCH, 5'd16, 1'b0, S_RS1, S_RS2, 32'h0},
   // jumps
   '{1'b1, 32'h1048, 32'h0010_00EF, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b1, 32'h1848, 3'b000, ALU_ADD, SEL_JUMP_BRANCH, 5'd1, 1'b1, S_ZERO, S_LIT, 32'h800},
   '{1'b1, 32'h104C, 32'h00C2_80E7, 1'b0, 1'b0, 1'b0, 32'h4001, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b1, 32'h400C, 3'b000, ALU_ADD, SEL_JUMP_BRANCH, 5'd1, 1'b1, S_RS1, S_LIT, 32'hC},
   // hold under downstream stall, then an invalid jump
   '{1'b1, 32'h1050, 32'h0640_8293, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_ARITH, 5'd5, 1'b1, S_RS1, S_LIT, 32'h64},
   '{1'b1, 32'h1054, 32'hFFB1_2313, 1'b0, 1'b1, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SLT, SEL_ARITH, 5'd6, 1'b1, S_RS1, S_LIT, 32'hFFFF_FFFB},
   '{1'b1, 32'h1054, 32'hFFB1_2313, 1'b0, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_SLT, SEL_ARITH, 5'd6, 1'b1, S_RS1, S_LIT, 32'hFFFF_FFFB},
   '{1'b0, 32'h1058, 32'h0010_00EF, 1'b1, 1'b0, 1'b1, 32'h0, 32'h0, NO_FWD, NO_FWD,
     1'b0, 1'b0, 32'h0, 3'b000, ALU_ADD, SEL_JUMP_BRANCH, 5'd1, 1'b1, S_ZERO, S_LIT, 32'h800}
};

`endif

/* bench/decode_stage_tb.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage_tb
   import rv_isa_pkg::*;
   import decode_pkg::*;
();

   localparam int          CLK_PERIOD = 100;
   localparam logic [31:0] SEED       = 32'h2003e00a;

   // where an expected operand comes from
   localparam logic [2:0] S_ZERO = 3'd0;
   localparam logic [2:0] S_RS1  = 3'd1;
   localparam logic [2:0] S_RS2  = 3'd2;
   localparam logic [2:0] S_EX   = 3'd3;
   localparam logic [2:0] S_MEM  = 3'd4;
   localparam logic [2:0] S_LIT  = 3'd5;

   localparam fwd_src_t NO_FWD = '0;

   typedef struct packed {
      logic       valid;
      word_t      pc;
      inst_t      inst;
      logic       pred;
      logic       stall;
      logic       rand_rf;                 // register file data from $urandom
      word_t      rs1_data;
      word_t      rs2_data;
      fwd_src_t   ex_fwd;
      fwd_src_t   mem_fwd;
      logic       exp_lu;
      logic       exp_redir;
      word_t      exp_redir_pc;
      bp_update_t exp_bp;
      alu_op_e    exp_op;
      alu_sel_e   exp_sel;
      reg_idx_t   exp_rd;
      logic       exp_we;
      logic [2:0] op1_src;
      logic [2:0] op2_src;
      word_t      exp_lit;                 // immediate operand, or the store offset
   } vec_row_t;

`include "decode_vectors.svh"

   localparam int WATCHDOG_NS = (NUM_ROWS + 20) * CLK_PERIOD;

   logic       clk;
   logic       arst_n_i;
   logic       inst_valid_i;
   word_t      pc_i;
   inst_t      inst_i;
   logic       pred_taken_i;
   fwd_src_t   ex_fwd_i;
   fwd_src_t   mem_fwd_i;
   word_t      rs1_data_i;
   word_t      rs2_data_i;
   logic       stall_i;
   reg_idx_t   rs1_addr_o;
   reg_idx_t   rs2_addr_o;
   logic       redirect_o;
   word_t      redirect_pc_o;
   bp_update_t bp_update_o;
   logic       load_use_stall_o;
   ex_bundle_t ex_bundle_o;

   word_t      cur_rs1;                    // register file data of the current row
   word_t      cur_rs2;
   ex_bundle_t exp_q;                      // model of the decode-to-execute register

   decode_stage UUT (
      .clk(clk), .arst_n_i(arst_n_i), .inst_valid_i(inst_valid_i), .pc_i(pc_i),
      .inst_i(inst_i), .pred_taken_i(pred_taken_i), .ex_fwd_i(ex_fwd_i),
      .mem_fwd_i(mem_fwd_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
      .stall_i(stall_i), .rs1_addr_o(rs1_addr_o), .rs2_addr_o(rs2_addr_o),
      .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o), .bp_update_o(bp_update_o),
      .load_use_stall_o(load_use_stall_o), .ex_bundle_o(ex_bundle_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run did not finish in time");
      $display("Test failed");
      $fatal(1, "watchdog");
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "first error");
      end
   endtask

   function automatic word_t operand_value(input logic [2:0] src, input vec_row_t r);
      case (src)
         S_ZERO:  operand_value = '0;
         S_RS1:   operand_value = cur_rs1;
         S_RS2:   operand_value = cur_rs2;
         S_EX:    operand_value = r.ex_fwd.data;
         S_MEM:   operand_value = r.mem_fwd.data;
         default: operand_value = r.exp_lit;
      endcase
   endfunction

   task automatic drive_row(input vec_row_t r);
      if (r.rand_rf)
      begin
         cur_rs1 = $urandom;
         cur_rs2 = $urandom;
      end
      else
      begin
         cur_rs1 = r.rs1_data;
         cur_rs2 = r.rs2_data;
      end
      inst_valid_i <= r.valid;
      pc_i         <= r.pc;
      inst_i       <= r.inst;
      pred_taken_i <= r.pred;
      stall_i      <= r.stall;
      ex_fwd_i     <= r.ex_fwd;
      mem_fwd_i    <= r.mem_fwd;
      rs1_data_i   <= cur_rs1;
      rs2_data_i   <= cur_rs2;
   endtask

   task automatic check_outputs(input vec_row_t r);
      compare_value("rs1_addr_o", 32'(rs1_addr_o), 32'(r.valid ? r.inst[19:15] : 5'd0));
      compare_value("rs2_addr_o", 32'(rs2_addr_o), 32'(r.valid ? r.inst[24:20] : 5'd0));
      compare_value("load_use_stall_o", 32'(load_use_stall_o), 32'(r.exp_lu));
      compare_value("redirect_o", 32'(redirect_o), 32'(r.exp_redir));
      if (r.exp_redir)
         compare_value("redirect_pc_o", redirect_pc_o, r.exp_redir_pc);
      compare_value("bp_update_o", 32'(bp_update_o), 32'(r.exp_bp));
   endtask

   // what the register holds after the edge that ends this row
   task automatic latch_expected(input vec_row_t r);
      if (!r.stall)
      begin
         exp_q.valid = r.valid && !r.exp_lu;
         if (!exp_q.valid)
         begin
            exp_q.we      = 1'b0;
            exp_q.alu_op  = ALU_NOP;
            exp_q.alu_sel = SEL_NOP;
         end
         else
         begin
            exp_q.alu_op    = r.exp_op;
            exp_q.alu_sel   = r.exp_sel;
            exp_q.rd        = r.exp_rd;
            exp_q.we        = r.exp_we;
            exp_q.op1       = operand_value(r.op1_src, r);
            exp_q.op2       = operand_value(r.op2_src, r);
            exp_q.mem_off   = r.exp_lit;
            exp_q.link_addr = r.pc + word_t'(`INST_STEP);
         end
      end
   endtask

   task automatic check_bundle();
      compare_value("bundle valid", 32'(ex_bundle_o.valid), 32'(exp_q.valid));
      compare_value("bundle we", 32'(ex_bundle_o.we), 32'(exp_q.we));
      compare_value("bundle alu_op", 32'(ex_bundle_o.alu_op), 32'(exp_q.alu_op));
      compare_value("bundle alu_sel", 32'(ex_bundle_o.alu_sel), 32'(exp_q.alu_sel));
      if (exp_q.valid)
      begin
         compare_value("bundle rd", 32'(ex_bundle_o.rd), 32'(exp_q.rd));
         compare_value("bundle op1", ex_bundle_o.op1, exp_q.op1);
         compare_value("bundle op2", ex_bundle_o.op2, exp_q.op2);
         compare_value("bundle link_addr", ex_bundle_o.link_addr, exp_q.link_addr);
         if (exp_q.alu_op == ALU_SW)
            compare_value("bundle mem_off", ex_bundle_o.mem_off, exp_q.mem_off);
      end
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      void'($urandom(SEED));
      arst_n_i     <= 1'b0;
      inst_valid_i <= 1'b0;
      pc_i         <= '0;
      inst_i       <= '0;
      pred_taken_i <= 1'b0;
      ex_fwd_i     <= '0;
      mem_fwd_i    <= '0;
      rs1_data_i   <= '0;
      rs2_data_i   <= '0;
      stall_i      <= 1'b0;
      cur_rs1 = '0;
      cur_rs2 = '0;
      exp_q   = '0;                        // bubble with op NOP

      repeat (10) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_bundle();

      // row i is driven on one edge and lands in the register on the next
      for (int i = 0; i <= NUM_ROWS; i++)
      begin
         @(posedge clk);
         if (i < NUM_ROWS)
            drive_row(vectors[i]);
         @(negedge clk);
         check_bundle();
         if (i < NUM_ROWS)
         begin
            check_outputs(vectors[i]);
            latch_expected(vectors[i]);
         end
      end

      $display("Test passed");
      $finish;
   end

endmodule

/* compile.f */
+incdir+verilog
+incdir+bench
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/operand_bypass.sv
verilog/branch_resolve.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
bench/decode_stage_tb.sv

/* Makefile */
TOP = decode_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module decode_stage

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
